// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // size of one instruction word.
    localparam int inst_width = 32;

    // base opcodes, all with the low two bits set for 32-bit encodings.
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [2:0] funct3_add = 3'b000;

    localparam logic [6:0] funct7_add = 7'b0000000;
    localparam logic [6:0] funct7_sub = 7'b0100000;

    // ebreak is the system opcode with this value in the upper twelve bits.
    localparam logic [11:0] funct12_ebreak = 12'h001;

    // lowest bit of each instruction field.
    localparam int opcode_lsb  = 0;
    localparam int rd_lsb      = 7;
    localparam int funct3_lsb  = 12;
    localparam int rs1_lsb     = 15;
    localparam int rs2_lsb     = 20;
    localparam int funct12_lsb = 20;
    localparam int funct7_lsb  = 25;

    // sign bit shared by every immediate format.
    localparam int sign_bit = 31;

endpackage

// ==== verilog/core_ops_pkg.sv ====
package core_ops_pkg;

    // operations the ALU performs on its two operands.
    typedef enum logic [1:0] {
        alu_add    = 2'b00,
        alu_sub    = 2'b01,
        alu_pass_b = 2'b10
    } alu_op_t;

    // source of the pc after an instruction executes.
    typedef enum logic [1:0] {
        npc_seq  = 2'b00,
        npc_jal  = 2'b01,
        npc_jalr = 2'b10
    } next_pc_t;

    // steps of one instruction through the core.
    typedef enum logic [2:0] {
        st_fetch = 3'd0,
        st_wait  = 3'd1,
        st_exec  = 3'd2,
        st_wb    = 3'd3,
        st_halt  = 3'd4
    } ctrl_state_t;

endpackage

// ==== verilog/core_ctrl.sv ====
`timescale 1ns/1ps

module core_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic fetch_ready,
    input  logic inst_valid,
    input  logic wb_ready,
    input  logic writes_reg,
    input  logic is_ebreak,
    output logic fetch_valid,
    output logic inst_ready,
    output logic wb_valid,
    output logic inst_load,
    output logic exec_en,
    output logic wb_fire,
    output logic halted
);
    import core_ops_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        started;

    // the first cycle out of reset stays idle, so the first request comes one cycle later.
    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_fetch: begin
                if (fetch_valid && fetch_ready) begin
                    state_next = st_wait;
                end
            end
            st_wait: begin
                if (inst_load) begin
                    state_next = st_exec;
                end
            end
            st_exec: begin
                if (is_ebreak) begin
                    state_next = st_halt;
                end else if (writes_reg) begin
                    state_next = st_wb;
                end else begin
                    state_next = st_fetch;
                end
            end
            st_wb: begin
                if (wb_fire) begin
                    state_next = st_fetch;
                end
            end
            default: begin
                state_next = st_halt;
            end
        endcase
    end

    assign fetch_valid = started && (state == st_fetch);
    assign inst_ready  = (state == st_wait);
    assign wb_valid    = (state == st_wb);
    assign halted      = (state == st_halt);

    assign inst_load = inst_valid && inst_ready;
    // ebreak leaves the pc and the result registers untouched.
    assign exec_en   = (state == st_exec) && !is_ebreak;
    assign wb_fire   = wb_valid && wb_ready;

endmodule

// ==== verilog/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
    parameter int                    data_width = 32,
    parameter logic [data_width-1:0] reset_pc   = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   exec_en,
    input  core_ops_pkg::next_pc_t next_pc_sel,
    input  logic [data_width-1:0]  imm,
    input  logic [data_width-1:0]  rs1_data,
    output logic [data_width-1:0]  pc,
    output logic [data_width-1:0]  link_addr
);
    import core_ops_pkg::*;

    logic [data_width-1:0] pc_next;
    logic [data_width-1:0] jalr_sum;

    assign link_addr = pc + data_width'(4);
    assign jalr_sum  = rs1_data + imm;

    always_comb begin
        case (next_pc_sel)
            npc_jal: begin
                pc_next = pc + imm;
            end
            npc_jalr: begin
                // jalr drops bit 0 of the computed target.
                pc_next = {jalr_sum[data_width-1:1], 1'b0};
            end
            default: begin
                pc_next = link_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (exec_en) begin
            pc <= pc_next;
        end
    end

    // jump targets come from decoded immediates and register values, and must stay aligned.
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode #(
    parameter int data_width = 32,
    parameter int addr_width = 5
) (
    input  logic [rv_isa_pkg::inst_width-1:0] inst,
    input  logic [data_width-1:0]             pc,
    input  logic [data_width-1:0]             link_addr,
    input  logic [data_width-1:0]             rs1_data,
    input  logic [data_width-1:0]             rs2_data,
    output logic [addr_width-1:0]             rs1_addr,
    output logic [addr_width-1:0]             rs2_addr,
    output logic [data_width-1:0]             alu_a,
    output logic [data_width-1:0]             alu_b,
    output core_ops_pkg::alu_op_t             alu_op,
    output logic [addr_width-1:0]             rd_addr,
    output logic [data_width-1:0]             imm,
    output core_ops_pkg::next_pc_t            next_pc_sel,
    output logic                              writes_reg,
    output logic                              is_ebreak
);
    import rv_isa_pkg::*;
    import core_ops_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [11:0]           funct12;
    logic [addr_width-1:0] rs1;
    logic [addr_width-1:0] rs2;
    logic [addr_width-1:0] rd;

    logic [data_width-1:0] imm_i;
    logic [data_width-1:0] imm_u;
    logic [data_width-1:0] imm_j;

    logic is_addi;
    logic is_add;
    logic is_sub;
    logic is_lui;
    logic is_auipc;
    logic is_jal;
    logic is_jalr;
    logic is_jump;
    logic supported;

    assign opcode  = inst[opcode_lsb +: 7];
    assign funct3  = inst[funct3_lsb +: 3];
    assign funct7  = inst[funct7_lsb +: 7];
    assign funct12 = inst[funct12_lsb +: 12];
    assign rs1     = inst[rs1_lsb +: addr_width];
    assign rs2     = inst[rs2_lsb +: addr_width];
    assign rd      = inst[rd_lsb +: addr_width];

    // the size casts sign-extend each immediate from its top bit.
    assign imm_i = data_width'($signed(inst[sign_bit:20]));
    assign imm_u = data_width'($signed({inst[sign_bit:12], 12'b0}));
    assign imm_j = data_width'($signed({inst[sign_bit], inst[19:12], inst[20],
                                        inst[30:21], 1'b0}));

    assign is_addi   = (opcode == opc_imm) && (funct3 == funct3_add);
    assign is_add    = (opcode == opc_op) && (funct3 == funct3_add) && (funct7 == funct7_add);
    assign is_sub    = (opcode == opc_op) && (funct3 == funct3_add) && (funct7 == funct7_sub);
    assign is_lui    = (opcode == opc_lui);
    assign is_auipc  = (opcode == opc_auipc);
    assign is_jal    = (opcode == opc_jal);
    assign is_jalr   = (opcode == opc_jalr) && (funct3 == funct3_add);
    assign is_ebreak = (opcode == opc_system) && (funct12 == funct12_ebreak);

    assign is_jump   = is_jal || is_jalr;
    assign supported = is_addi || is_add || is_sub || is_lui || is_auipc || is_jump;

    always_comb begin
        if (is_addi || is_jalr) begin
            imm = imm_i;
        end else if (is_lui || is_auipc) begin
            imm = imm_u;
        end else if (is_jal) begin
            imm = imm_j;
        end else begin
            imm = '0;
        end
    end

    // jumps write link_addr through an add of zero.
    assign alu_a = is_auipc ? pc : (is_jump ? link_addr : rs1_data);
    assign alu_b = is_jump ? '0 : ((is_add || is_sub) ? rs2_data : imm);

    assign alu_op = is_sub ? alu_sub : (is_lui ? alu_pass_b : alu_add);

    assign next_pc_sel = is_jal ? npc_jal : (is_jalr ? npc_jalr : npc_seq);

    assign rs1_addr = (is_addi || is_add || is_sub || is_jalr) ? rs1 : '0;
    assign rs2_addr = (is_add || is_sub) ? rs2 : '0;
    assign rd_addr  = rd;

    // unsupported opcodes fall through as no-ops.
    assign writes_reg = supported && (rd != '0);

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int data_width = 32
) (
    input  logic [data_width-1:0] alu_a,
    input  logic [data_width-1:0] alu_b,
    input  core_ops_pkg::alu_op_t alu_op,
    output logic [data_width-1:0] result
);
    import core_ops_pkg::*;

    always_comb begin
        case (alu_op)
            alu_add: begin
                result = alu_a + alu_b;
            end
            alu_sub: begin
                result = alu_a - alu_b;
            end
            alu_pass_b: begin
                // lui takes the shifted immediate as it is.
                result = alu_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int data_width = 32,
    parameter int addr_width = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addr_width-1:0] rs1_addr,
    input  logic [addr_width-1:0] rs2_addr,
    output logic [data_width-1:0] rs1_data,
    output logic [data_width-1:0] rs2_data,
    input  logic                  we,
    input  logic [addr_width-1:0] rd_addr,
    input  logic [data_width-1:0] rd_data
);
    localparam int num_regs = 1 << addr_width;

    logic [data_width-1:0] regs [num_regs];

    // x0 is cleared by reset and never written, so it always reads zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter int                    data_width = 32,
    parameter int                    addr_width = 5,
    parameter logic [data_width-1:0] reset_pc   = '0
) (
    input  logic                              clk,
    input  logic                              rst,
    output logic                              fetch_valid,
    output logic [data_width-1:0]             fetch_addr,
    input  logic                              fetch_ready,
    input  logic                              inst_valid,
    input  logic [rv_isa_pkg::inst_width-1:0] inst_data,
    output logic                              inst_ready,
    output logic                              wb_valid,
    output logic [addr_width-1:0]             wb_rd,
    output logic [data_width-1:0]             wb_data,
    input  logic                              wb_ready,
    output logic                              halted
);
    import rv_isa_pkg::*;
    import core_ops_pkg::*;

    logic                  inst_load;
    logic                  exec_en;
    logic                  wb_fire;
    logic                  writes_reg;
    logic                  is_ebreak;

    logic [inst_width-1:0] inst_q;
    logic [data_width-1:0] pc;
    logic [data_width-1:0] link_addr;
    logic [data_width-1:0] imm;
    next_pc_t              next_pc_sel;

    logic [addr_width-1:0] rs1_addr;
    logic [addr_width-1:0] rs2_addr;
    logic [data_width-1:0] rs1_data;
    logic [data_width-1:0] rs2_data;
    logic [addr_width-1:0] rd_addr;

    logic [data_width-1:0] alu_a;
    logic [data_width-1:0] alu_b;
    alu_op_t               alu_op;
    logic [data_width-1:0] result;

    logic [data_width-1:0] result_q;
    logic [addr_width-1:0] rd_q;

    always_ff @(posedge clk) begin
        if (inst_load) begin
            inst_q <= inst_data;
        end
    end

    // result and destination hold steady while the writeback beat waits.
    always_ff @(posedge clk) begin
        if (exec_en) begin
            result_q <= result;
            rd_q     <= rd_addr;
        end
    end

    assign fetch_addr = pc;
    assign wb_rd      = rd_q;
    assign wb_data    = result_q;

    core_ctrl core_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .fetch_ready (fetch_ready),
        .inst_valid  (inst_valid),
        .wb_ready    (wb_ready),
        .writes_reg  (writes_reg),
        .is_ebreak   (is_ebreak),
        .fetch_valid (fetch_valid),
        .inst_ready  (inst_ready),
        .wb_valid    (wb_valid),
        .inst_load   (inst_load),
        .exec_en     (exec_en),
        .wb_fire     (wb_fire),
        .halted      (halted)
    );

    pc_unit #(
        .data_width (data_width),
        .reset_pc   (reset_pc)
    ) pc_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .exec_en     (exec_en),
        .next_pc_sel (next_pc_sel),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .link_addr   (link_addr)
    );

    inst_decode #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) inst_decode_inst (
        .inst        (inst_q),
        .pc          (pc),
        .link_addr   (link_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_op      (alu_op),
        .rd_addr     (rd_addr),
        .imm         (imm),
        .next_pc_sel (next_pc_sel),
        .writes_reg  (writes_reg),
        .is_ebreak   (is_ebreak)
    );

    alu #(
        .data_width (data_width)
    ) alu_inst (
        .alu_a  (alu_a),
        .alu_b  (alu_b),
        .alu_op (alu_op),
        .result (result)
    );

    reg_file #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) reg_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_fire),
        .rd_addr  (rd_q),
        .rd_data  (result_q)
    );

    // a waiting fetch request keeps its address.
    assert property (@(posedge clk) disable iff (rst)
        fetch_valid && !fetch_ready |=> $stable(fetch_addr));

    // once halted, no writeback beat appears and the pc no longer moves.
    assert property (@(posedge clk) disable iff (rst)
        halted |=> !wb_valid && $stable(pc));

endmodule

// ==== verif/rv_core_prog.svh ====
`ifndef rv_core_prog_svh
`define rv_core_prog_svh

// instruction words by word address.
logic [31:0] prog_mem [0:63];

// expected writebacks in retirement order, one rd and value pair per entry.
logic [4:0]  exp_wb_rd [$];
logic [31:0] exp_wb_data [$];

// expected fetch addresses in request order.
logic [31:0] exp_fetch [$];

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, 3'b000, rd, opc};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [4:0] rd);
    return {funct7, rs2, rs1, 3'b000, rd, 7'h33};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

// the J format scatters the offset bits across the upper instruction half.
function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

task automatic expect_wb(input logic [4:0] rd, input logic [31:0] data);
    exp_wb_rd.push_back(rd);
    exp_wb_data.push_back(data);
endtask

task automatic load_program();
    // unused words carry their own index and an opcode the core does not support.
    for (int i = 0; i < 64; i++) begin
        prog_mem[i] = {i[24:0], 7'h7f};
    end
    prog_mem[0]  = i_type(12'd5, 5'd0, 5'd1, 7'h13);
    prog_mem[1]  = i_type(12'hffd, 5'd1, 5'd2, 7'h13);
    prog_mem[2]  = i_type(12'h800, 5'd2, 5'd3, 7'h13);
    prog_mem[3]  = u_type(20'h12345, 5'd4, 7'h37);
    prog_mem[4]  = u_type(20'h00001, 5'd5, 7'h17);
    prog_mem[5]  = r_type(7'h00, 5'd1, 5'd4, 5'd6);
    prog_mem[6]  = r_type(7'h20, 5'd4, 5'd1, 5'd7);
    prog_mem[7]  = u_type(20'h80000, 5'd8, 7'h37);
    prog_mem[8]  = r_type(7'h00, 5'd8, 5'd8, 5'd9);
    prog_mem[9]  = i_type(12'd7, 5'd1, 5'd0, 7'h13);
    prog_mem[10] = r_type(7'h00, 5'd1, 5'd0, 5'd10);
    prog_mem[11] = j_type(21'd12, 5'd11);
    prog_mem[12] = i_type(12'd1, 5'd0, 5'd12, 7'h13);
    prog_mem[13] = i_type(12'd2, 5'd0, 5'd12, 7'h13);
    prog_mem[14] = i_type(12'h045, 5'd0, 5'd13, 7'h13);
    prog_mem[15] = i_type(12'd4, 5'd13, 5'd14, 7'h67);
    prog_mem[16] = i_type(12'd3, 5'd0, 5'd12, 7'h13);
    prog_mem[17] = i_type(12'd4, 5'd0, 5'd12, 7'h13);
    prog_mem[18] = u_type(20'hfffff, 5'd15, 7'h17);
    prog_mem[19] = r_type(7'h20, 5'd5, 5'd3, 5'd16);
    // a store, which retires as a no-op here.
    prog_mem[20] = 32'h00112023;
    prog_mem[21] = r_type(7'h20, 5'd1, 5'd0, 5'd17);
    prog_mem[22] = 32'h00100073;

    expect_wb(5'd1, 32'h00000005);
    expect_wb(5'd2, 32'h00000002);
    expect_wb(5'd3, 32'hfffff802);
    expect_wb(5'd4, 32'h12345000);
    expect_wb(5'd5, 32'h00001010);
    expect_wb(5'd6, 32'h12345005);
    expect_wb(5'd7, 32'hedcbb005);
    expect_wb(5'd8, 32'h80000000);
    expect_wb(5'd9, 32'h00000000);
    expect_wb(5'd10, 32'h00000005);
    expect_wb(5'd11, 32'h00000030);
    expect_wb(5'd13, 32'h00000045);
    expect_wb(5'd14, 32'h00000040);
    expect_wb(5'd15, 32'hfffff048);
    expect_wb(5'd16, 32'hffffe7f2);
    expect_wb(5'd17, 32'hfffffffb);

    // straight line up to the jal, then the two jump targets.
    for (int a = 0; a <= 'h2c; a += 4) begin
        exp_fetch.push_back(a);
    end
    exp_fetch.push_back(32'h38);
    exp_fetch.push_back(32'h3c);
    for (int a = 'h48; a <= 'h58; a += 4) begin
        exp_fetch.push_back(a);
    end
endtask

`endif

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_ready;
    logic        inst_valid;
    logic [31:0] inst_data;
    logic        inst_ready;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        wb_ready;
    logic        halted;

    logic [31:0] seed;
    logic [31:0] rnd;
    logic        mem_busy;
    logic [31:0] mem_addr;
    logic [1:0]  mem_delay;
    logic        wb_held;
    logic [4:0]  held_rd;
    logic [31:0] held_data;

    int fetch_idx;
    int wb_idx;
    int value_errors;
    int other_errors;
    int cycles;

    `include "rv_core_prog.svh"

    rv_core #(
        .data_width (32),
        .addr_width (5),
        .reset_pc   (32'h0)
    ) rv_core_inst (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .inst_valid  (inst_valid),
        .inst_data   (inst_data),
        .inst_ready  (inst_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_ready    (wb_ready),
        .halted      (halted)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_fetch(input logic [31:0] addr);
        if (fetch_idx >= exp_fetch.size()) begin
            $display("FAIL @%0t: unexpected fetch of %h after the program end", $time, addr);
            value_errors++;
        end else if (addr !== exp_fetch[fetch_idx]) begin
            $display("FAIL @%0t: fetch %0d address %h, expected %h",
                     $time, fetch_idx, addr, exp_fetch[fetch_idx]);
            value_errors++;
        end
        fetch_idx++;
    endtask

    task automatic compare_writeback(input logic [4:0] rd, input logic [31:0] data);
        if (wb_idx >= exp_wb_rd.size()) begin
            $display("FAIL @%0t: unexpected writeback x%0d = %h", $time, rd, data);
            value_errors++;
        end else if (rd !== exp_wb_rd[wb_idx] || data !== exp_wb_data[wb_idx]) begin
            $display("FAIL @%0t: writeback %0d x%0d = %h, expected x%0d = %h", $time, wb_idx,
                     rd, data, exp_wb_rd[wb_idx], exp_wb_data[wb_idx]);
            value_errors++;
        end
        wb_idx++;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // the memory model and the writeback sink both sample the handshakes of the cycle just ended.
    always @(posedge clk) begin
        rnd = next_rand();
        if (rst) begin
            fetch_ready <= 1'b0;
            inst_valid  <= 1'b0;
            wb_ready    <= 1'b0;
            mem_busy    <= 1'b0;
            wb_held     <= 1'b0;
        end else begin
            if (!mem_busy) begin
                if (fetch_valid && fetch_ready) begin
                    check_fetch(fetch_addr);
                    mem_busy    <= 1'b1;
                    mem_addr    <= fetch_addr;
                    mem_delay   <= rnd[30:29];
                    fetch_ready <= 1'b0;
                    if (rnd[30:29] == 2'd0) begin
                        inst_valid <= 1'b1;
                        inst_data  <= prog_mem[fetch_addr[7:2]];
                    end
                end else begin
                    fetch_ready <= rnd[31];
                end
            end else if (inst_valid && inst_ready) begin
                inst_valid  <= 1'b0;
                mem_busy    <= 1'b0;
                fetch_ready <= rnd[31];
            end else if (!inst_valid) begin
                if (mem_delay == 2'd1) begin
                    inst_valid <= 1'b1;
                    inst_data  <= prog_mem[mem_addr[7:2]];
                end
                mem_delay <= mem_delay - 2'd1;
            end

            if (wb_valid) begin
                if (wb_held && (wb_rd !== held_rd || wb_data !== held_data)) begin
                    $display("FAIL @%0t: stalled writeback changed to x%0d = %h, was x%0d = %h",
                             $time, wb_rd, wb_data, held_rd, held_data);
                    value_errors++;
                end
                if (wb_ready) begin
                    compare_writeback(wb_rd, wb_data);
                    wb_held <= 1'b0;
                end else begin
                    wb_held   <= 1'b1;
                    held_rd   <= wb_rd;
                    held_data <= wb_data;
                end
            end else if (wb_held) begin
                $display("writeback valid dropped before it was accepted at %0t", $time);
                other_errors++;
                wb_held <= 1'b0;
            end
            wb_ready <= (rnd[28:27] != 2'd0);
        end
    end

    initial begin
        rst          = 1'b1;
        fetch_ready  = 1'b0;
        inst_valid   = 1'b0;
        inst_data    = 32'h0;
        wb_ready     = 1'b0;
        seed         = 32'h4ab5;
        fetch_idx    = 0;
        wb_idx       = 0;
        value_errors = 0;
        other_errors = 0;
        load_program();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (fetch_valid || inst_ready || wb_valid || halted) begin
            $display("FAIL @%0t: core outputs active in the first cycle after reset", $time);
            value_errors++;
        end

        cycles = 0;
        while (!halted && cycles < 3000) begin
            @(negedge clk);
            cycles++;
        end

        if (!halted) begin
            $display("timeout: the core did not halt within %0d cycles", cycles);
            other_errors++;
        end else begin
            // after ebreak the core must stay silent.
            cycles = 0;
            while (cycles < 40) begin
                @(negedge clk);
                if (fetch_valid || wb_valid || !halted) begin
                    $display("FAIL @%0t: activity after halt, fetch_valid %b wb_valid %b halted %b",
                             $time, fetch_valid, wb_valid, halted);
                    value_errors++;
                end
                cycles++;
            end
        end

        if (fetch_idx != exp_fetch.size()) begin
            $display("fetch count mismatch: saw %0d fetches, expected %0d",
                     fetch_idx, exp_fetch.size());
            other_errors++;
        end
        if (wb_idx != exp_wb_rd.size()) begin
            $display("writeback count mismatch: saw %0d beats, expected %0d",
                     wb_idx, exp_wb_rd.size());
            other_errors++;
        end

        $display("fetches %0d, writebacks %0d, value errors %0d, other errors %0d",
                 fetch_idx, wb_idx, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
+incdir+verif
verilog/rv_isa_pkg.sv
verilog/core_ops_pkg.sv
verilog/core_ctrl.sv
verilog/pc_unit.sv
verilog/inst_decode.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/rv_core.sv
verif/rv_core_tb.sv
